// ==== rtl/periph_pkg.sv ====
// shared definitions for the peripheral block
// clock ratios, APB widths and register offsets
// APB request and response structs, slot and SPI state enums

package periph_pkg;

	// --------------------
	// clocking
	// board clock in MHz, so one tick per microsecond
	localparam int TICK_DIV = 27;
	localparam int TICK_W   = $clog2(TICK_DIV);
	// clk cycles per half SPI clock period
	localparam int SPI_DIV  = 2;
	localparam int HALF_W   = $clog2(SPI_DIV + 1);

	// --------------------
	// APB
	localparam int PADDR_W = 16;
	localparam int PDATA_W = 32;

	// in-slot offset bits, the two top bits pick the slot
	localparam logic [PADDR_W-1:0] OFFSET_MASK = 16'h3fff;

	// timer registers
	localparam logic [PADDR_W-1:0] TMR_CTRL     = 16'h0000;
	localparam logic [PADDR_W-1:0] TMR_MTIME    = 16'h0004;
	localparam logic [PADDR_W-1:0] TMR_MTIMECMP = 16'h0008;

	// SD card SPI registers
	localparam logic [PADDR_W-1:0] SD_DATA   = 16'h0000;
	localparam logic [PADDR_W-1:0] SD_STATUS = 16'h0004;
	localparam logic [PADDR_W-1:0] SD_CTRL   = 16'h0008;

	typedef enum logic [1:0] {
		SLOT_TIMER = 2'd0,
		SLOT_SD    = 2'd1,
		SLOT_NONE  = 2'd3
	} slot_e;

	typedef enum logic [1:0] {
		SPI_IDLE = 2'd0,
		SPI_LOW  = 2'd1,
		SPI_HIGH = 2'd2
	} spi_state_e;

	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [PADDR_W-1:0] paddr;
		logic [PDATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [PDATA_W-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apb_resp_t;

	// zero wait state error answer
	localparam apb_resp_t APB_ERR = '{prdata: '0, pready: 1'b1, pslverr: 1'b1};

endpackage

// ==== rtl/apb_decode.sv ====
// APB slot decoder for the peripheral block
// splits bus traffic into timer and SD slots
// hands the SD slot to the boot loader until init_done

`timescale 1ns/1ps

module apb_decode (
	input  periph_pkg::apb_req_t  bus_req,
	input  periph_pkg::apb_req_t  boot_req,
	input  logic                  init_done,
	input  periph_pkg::apb_resp_t timer_resp,
	input  periph_pkg::apb_resp_t sd_resp,
	output periph_pkg::apb_resp_t bus_resp,
	output periph_pkg::apb_resp_t boot_resp,
	output periph_pkg::apb_req_t  timer_req,
	output periph_pkg::apb_req_t  sd_req
);

	periph_pkg::slot_e bus_slot;

	// address bits 15:14 select the device
	always_comb begin
		case (bus_req.paddr[15:14])
			2'd0:    bus_slot = periph_pkg::SLOT_TIMER;
			2'd1:    bus_slot = periph_pkg::SLOT_SD;
			default: bus_slot = periph_pkg::SLOT_NONE;
		endcase
	end

	// --------------------
	// requests
	always_comb begin
		timer_req = bus_req;
		timer_req.psel    = bus_req.psel & (bus_slot == periph_pkg::SLOT_TIMER);
		timer_req.penable = bus_req.penable & (bus_slot == periph_pkg::SLOT_TIMER);
	end

	// boot loader owns the SD port until init is done
	always_comb begin
		if (init_done) begin
			sd_req = bus_req;
			sd_req.psel    = bus_req.psel & (bus_slot == periph_pkg::SLOT_SD);
			sd_req.penable = bus_req.penable & (bus_slot == periph_pkg::SLOT_SD);
		end else begin
			sd_req = boot_req;
		end
	end

	// --------------------
	// responses
	always_comb begin
		case (bus_slot)
			periph_pkg::SLOT_TIMER: bus_resp = timer_resp;
			periph_pkg::SLOT_SD:    bus_resp = init_done ? sd_resp : periph_pkg::APB_ERR;
			default:                bus_resp = periph_pkg::APB_ERR;
		endcase
	end

	// boot side is locked out once the system owns the card
	assign boot_resp = init_done ? periph_pkg::APB_ERR : sd_resp;

endmodule

// ==== rtl/us_tick.sv ====
// microsecond timebase
// one-cycle tick every TICK_DIV clocks

`timescale 1ns/1ps

module us_tick (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	logic [periph_pkg::TICK_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			if (|cnt) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= periph_pkg::TICK_W'(periph_pkg::TICK_DIV - 1);
			end
			// pulse on the wrap
			tick <= ~|cnt;
		end
	end

endmodule

// ==== rtl/mtimer.sv ====
// RISC-V style machine timer, narrowed to 32 bits
// ctrl, mtime and mtimecmp on APB
// registered compare interrupt, counting frozen while the hart is halted

`timescale 1ns/1ps

module mtimer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  periph_pkg::apb_req_t  req,
	input  logic                  tick,
	input  logic                  dbg_halt,
	output periph_pkg::apb_resp_t resp,
	output logic                  timer_irq
);

	logic                           enable;
	logic [periph_pkg::PDATA_W-1:0] mtime;
	logic [periph_pkg::PDATA_W-1:0] mtimecmp;
	logic [periph_pkg::PADDR_W-1:0] offset;
	logic                           wr_en;

	assign offset = req.paddr & periph_pkg::OFFSET_MASK;
	assign wr_en  = req.psel & req.penable & req.pwrite;

	// --------------------
	// registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable   <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr_en && offset == periph_pkg::TMR_CTRL) begin
				enable <= req.pwdata[0];
			end
			if (wr_en && offset == periph_pkg::TMR_MTIMECMP) begin
				mtimecmp <= req.pwdata;
			end
			// software write wins over the count
			if (wr_en && offset == periph_pkg::TMR_MTIME) begin
				mtime <= req.pwdata;
			end else if (tick && enable && !dbg_halt) begin
				mtime <= mtime + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// --------------------
	// read side, zero wait states
	always_comb begin
		resp.pready  = 1'b1;
		resp.pslverr = 1'b0;
		case (offset)
			periph_pkg::TMR_CTRL:     resp.prdata = {31'b0, enable};
			periph_pkg::TMR_MTIME:    resp.prdata = mtime;
			periph_pkg::TMR_MTIMECMP: resp.prdata = mtimecmp;
			default:                  resp.prdata = '0;
		endcase
	end

endmodule

// ==== rtl/spi_fsm.sv ====
// SPI mode 0 bit sequencer
// sclk generation plus sample and shift strobes for one byte

`timescale 1ns/1ps

module spi_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic sclk,
	output logic shift_en,
	output logic sample_en,
	output logic busy
);

	periph_pkg::spi_state_e        state;
	logic [periph_pkg::HALF_W-1:0] half_cnt;
	logic [2:0]                    bit_cnt;
	logic                          half_end;

	assign half_end = (half_cnt == '0);

	// rising edge at the LOW to HIGH step, falling edge at HIGH to LOW
	assign sclk      = (state == periph_pkg::SPI_HIGH);
	assign sample_en = (state == periph_pkg::SPI_LOW) & half_end;
	assign shift_en  = (state == periph_pkg::SPI_HIGH) & half_end;
	assign busy      = (state != periph_pkg::SPI_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= periph_pkg::SPI_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				periph_pkg::SPI_IDLE: begin
					if (start) begin
						state    <= periph_pkg::SPI_LOW;
						half_cnt <= periph_pkg::HALF_W'(periph_pkg::SPI_DIV - 1);
						bit_cnt  <= '0;
					end
				end
				periph_pkg::SPI_LOW: begin
					if (half_end) begin
						state    <= periph_pkg::SPI_HIGH;
						half_cnt <= periph_pkg::HALF_W'(periph_pkg::SPI_DIV - 1);
					end else begin
						half_cnt <= half_cnt - 1'b1;
					end
				end
				periph_pkg::SPI_HIGH: begin
					if (half_end) begin
						half_cnt <= periph_pkg::HALF_W'(periph_pkg::SPI_DIV - 1);
						// last bit done after eight high phases
						if (bit_cnt == 3'd7) begin
							state <= periph_pkg::SPI_IDLE;
						end else begin
							state   <= periph_pkg::SPI_LOW;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end else begin
						half_cnt <= half_cnt - 1'b1;
					end
				end
				default: state <= periph_pkg::SPI_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/sd_spi.sv ====
// SD card SPI port on APB
// data, status and chip-select control registers
// byte shift register driven by the SPI sequencer

`timescale 1ns/1ps

module sd_spi (
	input  logic                  clk,
	input  logic                  rst_n,
	input  periph_pkg::apb_req_t  req,
	input  logic                  sd_miso,
	output periph_pkg::apb_resp_t resp,
	output logic                  sd_clk,
	output logic                  sd_mosi,
	output logic                  sd_cs_n
);

	logic [periph_pkg::PADDR_W-1:0] offset;
	logic                           wr_en;
	logic                           wr_data;
	logic                           start;
	logic                           busy;
	logic                           busy_q;
	logic                           shift_en;
	logic                           sample_en;
	logic [7:0]                     shreg;
	logic                           rx_bit;
	logic [7:0]                     rx_byte;
	logic                           cs_en;

	assign offset  = req.paddr & periph_pkg::OFFSET_MASK;
	assign wr_en   = req.psel & req.penable & req.pwrite;
	assign wr_data = wr_en & (offset == periph_pkg::SD_DATA);
	// a data write while busy is dropped
	assign start   = wr_data & ~busy;

	spi_fsm spi_fsm_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.sclk      (sd_clk),
		.shift_en  (shift_en),
		.sample_en (sample_en),
		.busy      (busy)
	);

	// --------------------
	// shift path, MSB first
	always_ff @(posedge clk) begin
		if (start) begin
			shreg <= req.pwdata[7:0];
		end else if (shift_en) begin
			shreg <= {shreg[6:0], rx_bit};
		end
		if (sample_en) begin
			rx_bit <= sd_miso;
		end
	end

	// line idles high between bytes
	assign sd_mosi = busy ? shreg[7] : 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			rx_byte <= '0;
			cs_en   <= 1'b0;
		end else begin
			busy_q <= busy;
			// byte complete once the sequencer drops busy
			if (busy_q && !busy) begin
				rx_byte <= shreg;
			end
			if (wr_en && offset == periph_pkg::SD_CTRL) begin
				cs_en <= req.pwdata[0];
			end
		end
	end

	assign sd_cs_n = ~cs_en;

	// --------------------
	// read side
	always_comb begin
		resp.pready  = 1'b1;
		resp.pslverr = wr_data & busy;
		case (offset)
			periph_pkg::SD_DATA:   resp.prdata = {24'b0, rx_byte};
			periph_pkg::SD_STATUS: resp.prdata = {30'b0, sd_cs_n, busy};
			periph_pkg::SD_CTRL:   resp.prdata = {31'b0, cs_en};
			default:               resp.prdata = '0;
		endcase
	end

endmodule

// ==== rtl/periph_top.sv ====
// low-speed peripheral block below the APB bridge
// slot decoder, microsecond timebase, machine timer, SD card SPI

`timescale 1ns/1ps

module periph_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  periph_pkg::apb_req_t  bus_req,
	input  periph_pkg::apb_req_t  boot_req,
	input  logic                  init_done,
	input  logic                  dbg_halt,
	input  logic                  sd_miso,
	output periph_pkg::apb_resp_t bus_resp,
	output periph_pkg::apb_resp_t boot_resp,
	output logic                  timer_irq,
	output logic                  sd_clk,
	output logic                  sd_mosi,
	output logic                  sd_cs_n
);

	periph_pkg::apb_req_t  timer_req;
	periph_pkg::apb_req_t  sd_req;
	periph_pkg::apb_resp_t timer_resp;
	periph_pkg::apb_resp_t sd_resp;
	logic                  tick;

	// --------------------
	// bus routing
	apb_decode apb_decode_i (
		.bus_req    (bus_req),
		.boot_req   (boot_req),
		.init_done  (init_done),
		.timer_resp (timer_resp),
		.sd_resp    (sd_resp),
		.bus_resp   (bus_resp),
		.boot_resp  (boot_resp),
		.timer_req  (timer_req),
		.sd_req     (sd_req)
	);

	// --------------------
	// timer
	us_tick us_tick_i (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	mtimer mtimer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (timer_req),
		.tick      (tick),
		.dbg_halt  (dbg_halt),
		.resp      (timer_resp),
		.timer_irq (timer_irq)
	);

	// --------------------
	// SD card
	sd_spi sd_spi_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (sd_req),
		.sd_miso (sd_miso),
		.resp    (sd_resp),
		.sd_clk  (sd_clk),
		.sd_mosi (sd_mosi),
		.sd_cs_n (sd_cs_n)
	);

endmodule

// ==== bench/periph_tb.sv ====
// testbench for the peripheral block
// command sequence and expected values from bench/tb_input.txt
// SD loopback with miso tied to mosi

`timescale 1ns/1ps

module periph_tb;

	localparam int MAX_CMDS = 64;

	logic                  clk;
	logic                  rst_n;
	periph_pkg::apb_req_t  bus_req;
	periph_pkg::apb_req_t  boot_req;
	logic                  init_done;
	logic                  dbg_halt;
	logic                  sd_miso;
	periph_pkg::apb_resp_t bus_resp;
	periph_pkg::apb_resp_t boot_resp;
	logic                  timer_irq;
	logic                  sd_clk;
	logic                  sd_mosi;
	logic                  sd_cs_n;

	logic [31:0] stim [0:5*MAX_CMDS-1];
	logic [31:0] saved;
	int          errors;
	int          checks;
	int          cycles;
	int          limit;
	int          test_id;
	int          sclk_rises;
	int          sclk_seen;

	periph_top periph_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.bus_req   (bus_req),
		.boot_req  (boot_req),
		.init_done (init_done),
		.dbg_halt  (dbg_halt),
		.sd_miso   (sd_miso),
		.bus_resp  (bus_resp),
		.boot_resp (boot_resp),
		.timer_irq (timer_irq),
		.sd_clk    (sd_clk),
		.sd_mosi   (sd_mosi),
		.sd_cs_n   (sd_cs_n)
	);

	// received byte equals the byte sent
	assign sd_miso = sd_mosi;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, command sequence did not finish", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// SPI clock pulses seen on the card side
	always @(posedge sd_clk) begin
		sclk_rises <= sclk_rises + 1;
	end

	function automatic string test_name(input int id);
		case (id)
			0:       return "reset_values";
			1:       return "unmapped_access";
			2:       return "timer_count_irq";
			3:       return "debug_freeze";
			4:       return "sd_boot_ownership";
			default: return "unknown_test";
		endcase
	endfunction

	// --------------------
	// one APB transfer, entered and left 2 ns after a rising edge
	task automatic apb_access(input logic port, input logic write, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		periph_pkg::apb_req_t  req;
		periph_pkg::apb_resp_t resp;
		req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		if (port) boot_req = req;
		else bus_req = req;
		@(posedge clk);
		#2;
		req.penable = 1'b1;
		if (port) boot_req = req;
		else bus_req = req;
		// response is stable in the middle of the access cycle
		@(negedge clk);
		resp = port ? boot_resp : bus_resp;
		rdata = resp.prdata;
		err = resp.pslverr;
		checks++;
		if (resp.pready !== 1'b1) begin
			errors++;
			$display("[ERROR] %s: pready at %h expected 1 actual %b",
				test_name(test_id), addr, resp.pready);
		end
		@(posedge clk);
		#2;
		bus_req = '0;
		boot_req = '0;
	endtask

	task automatic check_value(input string what, input logic [15:0] addr,
		input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: %s at %h expected %h actual %h",
				test_name(test_id), what, addr, exp, act);
		end
	endtask

	task automatic wait_irq(input logic level, input int budget);
		int   n;
		logic seen;
		n = 0;
		@(negedge clk);
		seen = timer_irq;
		while (seen !== level && n < budget) begin
			@(negedge clk);
			seen = timer_irq;
			n++;
		end
		@(posedge clk);
		#2;
		checks++;
		if (seen !== level) begin
			errors++;
			$display("[ERROR] %s: timer_irq expected %0b actual %0b after %0d cycles",
				test_name(test_id), level, seen, n);
		end
	endtask

	task automatic poll_idle(input logic port, input logic [15:0] base, input int budget);
		int          spent;
		logic [31:0] status;
		logic        err;
		spent = 2;
		apb_access(port, 1'b0, base | periph_pkg::SD_STATUS, 32'd0, status, err);
		while (status[0] && spent < budget) begin
			apb_access(port, 1'b0, base | periph_pkg::SD_STATUS, 32'd0, status, err);
			spent += 2;
		end
		checks++;
		if (status[0]) begin
			errors++;
			$display("%s: SD transfer still busy after %0d cycles", test_name(test_id), spent);
		end
		// one sclk pulse per bit, eight bits per byte
		checks++;
		if (sclk_rises - sclk_seen != 8) begin
			errors++;
			$display("[ERROR] %s: sd_clk rises expected 8 actual %0d",
				test_name(test_id), sclk_rises - sclk_seen);
		end
		sclk_seen = sclk_rises;
	endtask

	// --------------------
	// command interpreter
	initial begin
		int          pc;
		int          i;
		logic        done;
		logic [3:0]  cmd;
		logic        port;
		logic [15:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		logic [31:0] rdata;
		logic        err;
		errors = 0;
		checks = 0;
		cycles = 0;
		test_id = 0;
		sclk_seen = 0;
		saved = '0;
		rst_n = 1'b0;
		init_done = 1'b0;
		dbg_halt = 1'b0;
		bus_req = '0;
		boot_req = '0;
		$readmemh("bench/tb_input.txt", stim);
		// wait, poll and irq budgets plus a few cycles per command
		limit = 200;
		for (i = 0; i < MAX_CMDS; i++) begin
			case (stim[5*i][3:0])
				4'h6, 4'h7, 4'ha: limit += int'(stim[5*i+3]) + 4;
				default:          limit += 4;
			endcase
		end
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		pc = 0;
		done = 1'b0;
		while (!done && pc < MAX_CMDS) begin
			cmd  = stim[5*pc][3:0];
			port = stim[5*pc+1][0];
			addr = stim[5*pc+2][15:0];
			data = stim[5*pc+3];
			exp  = stim[5*pc+4];
			case (cmd)
				4'h0: done = 1'b1;
				4'h1: test_id = int'(data);
				4'h2, 4'h4: begin
					apb_access(port, 1'b1, addr, data, rdata, err);
					check_value("write pslverr", addr, {31'b0, cmd == 4'h4}, {31'b0, err});
				end
				4'h3, 4'h5: begin
					apb_access(port, 1'b0, addr, 32'd0, rdata, err);
					check_value("read pslverr", addr, {31'b0, cmd == 4'h5}, {31'b0, err});
					check_value("read data", addr, exp, rdata);
				end
				4'h6: poll_idle(port, addr, int'(data));
				4'h7: begin
					repeat (data) @(posedge clk);
					#2;
				end
				4'h8: init_done = data[0];
				4'h9: dbg_halt = data[0];
				4'ha: wait_irq(exp[0], int'(data));
				4'hb: begin
					apb_access(port, 1'b0, addr, 32'd0, rdata, err);
					checks++;
					if (rdata + 32'd1 < exp || rdata > exp + 32'd1) begin
						errors++;
						$display("[ERROR] %s: count at %h expected %h +-1 actual %h",
							test_name(test_id), addr, exp, rdata);
					end
				end
				4'hc: begin
					apb_access(port, 1'b0, addr, 32'd0, rdata, err);
					saved = rdata;
				end
				4'hd: begin
					apb_access(port, 1'b0, addr, 32'd0, rdata, err);
					checks++;
					if (exp[0] ? (rdata <= saved) : (rdata != saved)) begin
						errors++;
						$display("[ERROR] %s: count at %h expected %s %h actual %h",
							test_name(test_id), addr, exp[0] ? "above" : "equal to", saved, rdata);
					end
				end
				4'he: begin
					@(negedge clk);
					rdata = {28'b0, sd_mosi, sd_cs_n, sd_clk, timer_irq};
					@(posedge clk);
					#2;
					check_value("pins", addr, exp, rdata);
				end
				default: begin
					errors++;
					$display("unknown command %h in stimulus entry %0d", cmd, pc);
				end
			endcase
			pc++;
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== list.f ====
rtl/periph_pkg.sv
rtl/apb_decode.sv
rtl/us_tick.sv
rtl/mtimer.sv
rtl/spi_fsm.sv
rtl/sd_spi.sv
rtl/periph_top.sv
bench/periph_tb.sv

// ==== Makefile ====
# Verilator simulation of the peripheral block
VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_input.txt ====
// columns: command port address data expected, all hex, port 0 bus and 1 boot
// commands: 1 test, 2 wr, 3 rd, 4 wr err, 5 rd err, 6 poll, 7 wait, 8 init, 9 halt, a irq,
// b rd near, c capture, d compare, e pins, 0 end
1 0 0000 0        0
3 0 0000 0        0          // ctrl
3 0 0004 0        0          // mtime
3 0 0008 0        ffffffff   // mtimecmp
3 1 4004 0        2          // SD status via boot port
e 0 0000 0        c          // mosi, cs_n, sclk, irq
1 0 0000 1        0
5 0 8000 0        0
1 0 0000 2        0
2 0 0004 0        0
2 0 0000 1        0
7 0 0000 10e      0          // 270 cycles
b 0 0004 0        a          // 270 / 27
2 0 0004 0        0
2 0 0008 3        0
a 0 0000 6e       1          // 4 * 27 + 2
2 0 0008 ffffffff 0
a 0 0000 2        0
1 0 0000 3        0
9 0 0000 1        0
c 0 0004 0        0
7 0 0000 64       0
d 0 0004 0        0          // frozen
9 0 0000 0        0
7 0 0000 3c       0
d 0 0004 0        1          // counting again
1 0 0000 4        0
2 1 4008 1        0
2 1 4000 a5       0
3 1 4004 0        1          // busy with cs asserted
5 0 4000 0        0
6 1 4000 40       0
3 1 4000 0        a5
8 0 0000 1        0
2 0 4000 3c       0
4 0 4000 55       0          // dropped while busy
5 1 4004 0        0
6 0 4000 40       0
3 0 4000 0        3c
2 0 4008 0        0
3 0 4004 0        2
0 0 0000 0        0
